// ==== cpu.f ====
+incdir+.
cpuPkg.sv
cpuIf.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memStage.sv
cpu.sv
cpu_assert.sv
cpu_check.sv
cpu_tb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb \
	-f cpu.f --Mdir obj_dir -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "compile failed, see build.log"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" sim.log; then
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "no pass line in sim.log"
	exit 1
fi
exit 0

// ==== cpu_tb.sv ====
`include "cpu_settings.svh"

module cpuTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int numProgs = 21;   // directed plus 20 random
	localparam int progWords = 28;
	localparam int clkPeriod = 40;

	logic        clk;
	logic        arstN;
	logic        imemWe;
	logic [7:0]  imemAddr;
	logic [15:0] imemData;
	logic        memRe;
	logic        memWe;
	logic [15:0] memAddr;
	logic [15:0] memWdata;
	logic [15:0] memRdata;
	logic        hlt;
	logic [15:0] pc;
	logic        dmemInit;             // reload data memory start values
	logic [15:0] dmem [64];
	logic [15:0] prog [progWords];
	logic [15:0] expAddr [64];
	logic [15:0] expData [64];
	int          expCount;
	int          expLoads;
	logic [15:0] expHaltPc;
	logic        progDone;
	int          storeErrs;
	int          haltErrs;
	logic [15:0] lfsr;

	cpu UUT (.clk(clk), .arstN(arstN), .imemWe(imemWe), .imemAddr(imemAddr),
		.imemData(imemData), .memRe(memRe), .memWe(memWe), .memAddr(memAddr),
		.memWdata(memWdata), .memRdata(memRdata), .hlt(hlt), .pc(pc));

	cpuCheck busCheck (.clk(clk), .arstN(arstN), .memRe(memRe), .memWe(memWe),
		.memAddr(memAddr), .memWdata(memWdata), .hlt(hlt), .pc(pc), .expAddr(expAddr),
		.expData(expData), .expCount(expCount), .expLoadCount(expLoads),
		.expHaltPc(expHaltPc), .progDone(progDone), .storeErrs(storeErrs),
		.haltErrs(haltErrs));

	bind cpu cpuAssert assertChk (.clk(clk), .arstN(arstN), .memRe(memRe), .memWe(memWe),
		.hlt(hlt));

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// data memory with same-cycle read
	assign memRdata = dmem[memAddr[5:0]];
	always @(posedge clk) begin
		if (dmemInit) begin
			for (int i = 0; i < 64; i++)
				dmem[i] <= memInit(i);
		end else if (memWe) begin
			dmem[memAddr[5:0]] <= memWdata;
		end
	end

	function automatic logic [15:0] memInit(input int i);
		return 16'(i * 16'h0751) ^ 16'h5A3C;  // every address bit matters
	endfunction

	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
	endfunction

	task automatic takeBits(input int n, output logic [15:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsrStep(lfsr);
			v    = {v[14:0], lfsr[0]};           // one step per bit
		end
	endtask

	function automatic logic [3:0] opTable(input logic [3:0] sel);
		case (sel)
			4'd0, 4'd13:         return 4'd0;   // add
			4'd1:                return 4'd1;   // sub
			4'd2, 4'd14:         return 4'd2;   // xor
			4'd3, 4'd4:          return 4'd3;   // addi
			4'd5, 4'd6:          return 4'd8;   // lw
			4'd7, 4'd8:          return 4'd9;   // sw
			4'd9:                return 4'd10;  // llb
			4'd10:               return 4'd11;  // lhb
			4'd11, 4'd12:        return 4'd12;  // bz
			default:             return 4'd5;   // unused opcode, no-op
		endcase
	endfunction

	function automatic logic [15:0] directedWord(input int i);
		case (i)
			0:  return 16'hA134;  // llb r1, 34
			1:  return 16'hB112;  // lhb r1, 12
			2:  return 16'h3215;  // addi r2, r1, 5
			3:  return 16'h1321;  // sub r3, r2, r1
			4:  return 16'h9300;  // sw r3, 0(r0)
			5:  return 16'h8401;  // lw r4, 1(r0)
			6:  return 16'h0543;  // add r5, r4, r3 load-use
			7:  return 16'h9502;  // sw r5, 2(r0)
			8:  return 16'h2655;  // xor r6, r5, r5 sets z
			9:  return 16'hC001;  // bz +1 taken
			10: return 16'h9103;  // sw r1 flushed
			11: return 16'h366F;  // addi r6, r6, -1 clears z
			12: return 16'hC001;  // bz not taken
			13: return 16'h9604;  // sw r6, 4(r0)
			default: return 16'hF000;
		endcase
	endfunction

	task automatic genRandom();
		logic [15:0] sel;
		logic [15:0] rd;
		logic [15:0] rs;
		logic [15:0] rt;
		logic [3:0]  op;
		for (int i = 0; i < progWords; i++) begin
			if (i >= 24) begin
				prog[i] = 16'hF000;            // halt pad covers any forward bz
			end else begin
				takeBits(4, sel);
				takeBits(3, rd);               // r0..r7 keeps dependencies dense
				takeBits(3, rs);
				takeBits(4, rt);
				op = opTable(sel[3:0]);
				case (op)
					4'd8, 4'd9: prog[i] = {op, rd[3:0], 2'b00, rs[1:0], rt[3:0]};
					4'd12:      prog[i] = {op, 4'h0, 6'h00, rt[1:0]};
					default:    prog[i] = {op, rd[3:0], rs[3:0], rt[3:0]};
				endcase
			end
		end
	endtask

	// isa-level model that fills the expected stores and returns the halt address
	function automatic logic [15:0] refRun();
		logic [15:0] r [16];
		logic [15:0] dm [64];
		logic [15:0] pcv;
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] imm;
		logic [15:0] res;
		logic [15:0] nextPc;
		logic        z;
		int          rd;
		for (int i = 0; i < 16; i++)
			r[i] = '0;
		for (int i = 0; i < 64; i++)
			dm[i] = memInit(i);
		pcv      = '0;
		z        = 1'b0;
		expCount = 0;
		expLoads = 0;
		for (int step = 0; step < 256; step++) begin
			ins    = prog[pcv[5:1]];
			rd     = int'(ins[11:8]);
			a      = r[ins[7:4]];
			b      = r[ins[3:0]];
			imm    = {{12{ins[3]}}, ins[3:0]};
			nextPc = pcv + 16'd2;
			case (ins[15:12])
				4'd0, 4'd1, 4'd2, 4'd3: begin
					if (ins[15:12] == 4'd0)      res = a + b;
					else if (ins[15:12] == 4'd1) res = a - b;
					else if (ins[15:12] == 4'd2) res = a ^ b;
					else                         res = a + imm;
					z     = (res == 16'd0);
					r[rd] = res;
				end
				4'd8: begin
					res   = a + imm;
					r[rd] = dm[res[5:0]];
					expLoads++;
				end
				4'd9: begin
					res                = a + imm;
					dm[res[5:0]]       = r[rd];
					expAddr[expCount]  = res;
					expData[expCount]  = r[rd];
					expCount++;
				end
				4'd10: r[rd] = {r[rd][15:8], ins[7:0]};
				4'd11: r[rd] = {ins[7:0], r[rd][7:0]};
				4'd12: if (z) nextPc = nextPc + {{7{ins[7]}}, ins[7:0], 1'b0};
				4'd15: return pcv;
				default: ;                           // no-op
			endcase
			r[0] = '0;
			pcv  = nextPc;
		end
		return 16'hFFFF;                            // ran away without a halt
	endfunction

	task automatic runProgram();
		@(posedge clk);
		#2;
		arstN    = 1'b0;
		dmemInit = 1'b1;
		for (int i = 0; i < progWords; i++) begin
			imemWe   = 1'b1;
			imemAddr = 8'(i);
			imemData = prog[i];
			@(posedge clk);
			#2;
		end
		imemWe   = 1'b0;
		dmemInit = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		arstN = 1'b1;
		@(posedge clk);
		while (!progDone)
			@(posedge clk);
	endtask

	initial begin
		arstN    = 1'b0;
		imemWe   = 1'b0;
		imemAddr = '0;
		imemData = '0;
		dmemInit = 1'b0;
		lfsr     = 16'd50083;
		expCount = 0;
		expLoads = 0;
		for (int p = 0; p < numProgs; p++) begin
			if (p == 0) begin
				for (int i = 0; i < progWords; i++)
					prog[i] = directedWord(i);
			end else begin
				genRandom();
			end
			expHaltPc = refRun();
			runProgram();
		end
		$display("errors: store %0d, halt %0d", storeErrs, haltErrs);
		if (storeErrs == 0 && haltErrs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		#(numProgs * 400 * clkPeriod);
		$display("timeout: a program did not reach its halt in time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== cpu_check.sv ====
module cpuCheck (
	input  logic        clk,
	input  logic        arstN,
	input  logic        memRe,
	input  logic        memWe,
	input  logic [15:0] memAddr,
	input  logic [15:0] memWdata,
	input  logic        hlt,
	input  logic [15:0] pc,
	input  logic [15:0] expAddr [64],  // expected store stream
	input  logic [15:0] expData [64],
	input  int          expCount,
	input  int          expLoadCount,  // loads on the reference path
	input  logic [15:0] expHaltPc,
	output logic        progDone,      // halt seen for current program
	output int          storeErrs,
	output int          haltErrs
);

	timeunit 1ns;
	timeprecision 100ps;

	int storeIdx;
	int loadCount;
	int nStoreErr = 0;  // totals over all programs
	int nHaltErr = 0;

	assign storeErrs = nStoreErr;
	assign haltErrs  = nHaltErr;

	// dut outputs sampled on the rising edge where they are settled
	always @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			storeIdx  <= 0;
			loadCount <= 0;
			progDone  <= 1'b0;
		end else begin
			if (memRe)
				loadCount <= loadCount + 1;
			if (memWe) begin
				if (progDone) begin
					$display("store at %0t issued after the halt", $time);
					nStoreErr++;
				end else if (storeIdx >= expCount) begin
					$display("unexpected extra store at %0t to address %h", $time, memAddr);
					nStoreErr++;
				end else begin
					if (memAddr !== expAddr[storeIdx]) begin
						$display("FAIL time=%0t signal=memAddr expected=%h actual=%h",
							$time, expAddr[storeIdx], memAddr);
						nStoreErr++;
					end
					if (memWdata !== expData[storeIdx]) begin
						$display("FAIL time=%0t signal=memWdata expected=%h actual=%h",
							$time, expData[storeIdx], memWdata);
						nStoreErr++;
					end
				end
				storeIdx <= storeIdx + 1;
			end
			if (hlt && !progDone) begin // first cycle of halt
				progDone <= 1'b1;
				if (pc !== expHaltPc) begin
					$display("FAIL time=%0t signal=pc expected=%h actual=%h",
						$time, expHaltPc, pc);
					nHaltErr++;
				end
				if (storeIdx != expCount) begin
					$display("halt at %0t after %0d stores, expected %0d stores",
						$time, storeIdx, expCount);
					nHaltErr++;
				end
				if (loadCount != expLoadCount) begin
					$display("halt at %0t after %0d loads, expected %0d loads",
						$time, loadCount, expLoadCount);
					nHaltErr++;
				end
			end
		end
	end

endmodule

// ==== cpu_assert.sv ====
module cpuAssert (
	input logic clk,
	input logic arstN,
	input logic memRe,
	input logic memWe,
	input logic hlt
);

	timeunit 1ns;
	timeprecision 100ps;

	// once halted the core must stay quiet on the bus
	noStoreAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
		hlt |-> !memWe)
		else $error("store strobe seen while hlt is high");

	// a single bus op per cycle
	oneStrobe: assert property (@(posedge clk) !(memRe && memWe))
		else $error("memRe and memWe high together");

	// outputs idle while reset is held
	quietInReset: assert property (@(posedge clk) !arstN |-> (!memRe && !memWe && !hlt))
		else $error("bus strobe or hlt active during reset");

	// hlt is sticky until reset
	hltSticky: assert property (@(posedge clk) disable iff (!arstN)
		hlt |=> hlt)
		else $error("hlt dropped without reset");

endmodule

// ==== cpu.sv ====
`include "cpu_settings.svh"

module cpu (
	input  logic                      clk,
	input  logic                      arstN,
	input  logic                      imemWe,
	input  logic [`CPU_IMEM_BITS-1:0] imemAddr,
	input  logic [`CPU_XLEN-1:0]      imemData,
	output logic                      memRe,
	output logic                      memWe,
	output logic [`CPU_XLEN-1:0]      memAddr,
	output logic [`CPU_XLEN-1:0]      memWdata,
	input  logic [`CPU_XLEN-1:0]      memRdata,
	output logic                      hlt,
	output logic [`CPU_XLEN-1:0]      pc
);

	logic [`CPU_XLEN-1:0] instr;       // fetch/decode register
	logic [`CPU_XLEN-1:0] pcPlus2;
	logic                 fetchValid;
	logic                 stall;       // load-use hold
	logic                 redirect;    // taken bz
	logic [`CPU_XLEN-1:0] redirectPc;

	decExIf dxBus ();
	exMemIf xmBus ();
	wbIf    wbBus ();

	fetchStage iFetch (.clk(clk), .arstN(arstN), .imemWe(imemWe), .imemAddr(imemAddr),
		.imemData(imemData), .stall(stall), .redirect(redirect), .redirectPc(redirectPc),
		.pc(pc), .instr(instr), .pcPlus2(pcPlus2), .fetchValid(fetchValid));

	decodeStage iDecode (.clk(clk), .arstN(arstN), .instr(instr), .pcPlus2(pcPlus2),
		.fetchValid(fetchValid), .redirect(redirect), .stall(stall),
		.wb(wbBus.consumer), .dx(dxBus.producer));

	executeStage iExecute (.clk(clk), .arstN(arstN), .dx(dxBus.consumer),
		.wb(wbBus.consumer), .xm(xmBus.producer), .redirect(redirect),
		.redirectPc(redirectPc));

	memStage iMem (.clk(clk), .arstN(arstN), .xm(xmBus.consumer), .memRe(memRe),
		.memWe(memWe), .memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata),
		.wb(wbBus.producer), .hlt(hlt));

endmodule

// ==== memStage.sv ====
`include "cpu_settings.svh"

module memStage (
	input  logic                 clk,
	input  logic                 arstN,
	exMemIf.consumer             xm,
	output logic                 memRe,
	output logic                 memWe,
	output logic [`CPU_XLEN-1:0] memAddr,
	output logic [`CPU_XLEN-1:0] memWdata,
	input  logic [`CPU_XLEN-1:0] memRdata,
	wbIf.producer                wb,
	output logic                 hlt
);

	logic                 wbWrite;   // valid and regWrite folded together
	logic                 wbHalt;
	logic                 hltSticky;
	logic [`CPU_XLEN-1:0] resultSel;

	// single-cycle strobes, address and data only matter while one is up
	assign memRe    = xm.valid && xm.ctrl.memRead;
	assign memWe    = xm.valid && xm.ctrl.memWrite;
	assign memAddr  = xm.aluResult;
	assign memWdata = xm.storeData;

	assign resultSel = xm.ctrl.memRead ? memRdata : xm.aluResult; // load data is same-cycle

	// load results are not forwarded from here, decode stalls for them instead
	assign wb.memFwdEn   = xm.valid && xm.ctrl.regWrite && !xm.ctrl.memRead &&
		xm.ctrl.dstReg != '0;
	assign wb.memFwdReg  = xm.ctrl.dstReg;
	assign wb.memFwdData = xm.aluResult;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wbWrite   <= 1'b0;
			wbHalt    <= 1'b0;
			hltSticky <= 1'b0;
		end else begin
			wbWrite   <= xm.valid && xm.ctrl.regWrite;
			wbHalt    <= xm.valid && xm.ctrl.isHalt;
			hltSticky <= hltSticky || wbHalt;        // held until reset
		end
	end

	always_ff @(posedge clk) begin
		wb.wbReg  <= xm.ctrl.dstReg;
		wb.wbData <= resultSel;
	end

	assign wb.wbEn = wbWrite && wb.wbReg != '0;       // r0 never written
	assign hlt     = hltSticky || wbHalt;             // up in the cycle halt hits writeback

endmodule

// ==== executeStage.sv ====
`include "cpu_settings.svh"

module executeStage (
	input  logic                 clk,
	input  logic                 arstN,
	decExIf.consumer             dx,
	wbIf.consumer                wb,
	exMemIf.producer             xm,
	output logic                 redirect,
	output logic [`CPU_XLEN-1:0] redirectPc
);

	logic [`CPU_XLEN-1:0] opA;
	logic [`CPU_XLEN-1:0] opB;
	logic [`CPU_XLEN-1:0] aluA;
	logic [`CPU_XLEN-1:0] aluB;
	logic [`CPU_XLEN-1:0] aluResult;
	logic [`CPU_XLEN-1:0] branchOfs;
	logic                 zeroFlag;

	// youngest producer wins, enables are already false for r0
	assign opA = (wb.memFwdEn && wb.memFwdReg == dx.src1) ? wb.memFwdData :
		(wb.wbEn && wb.wbReg == dx.src1) ? wb.wbData : dx.operand1;
	assign opB = (wb.memFwdEn && wb.memFwdReg == dx.src2) ? wb.memFwdData :
		(wb.wbEn && wb.wbReg == dx.src2) ? wb.wbData : dx.operand2;

	assign aluA = dx.ctrl.memWrite ? opB : opA;        // sw base sits in the second slot
	assign aluB = dx.ctrl.useImm ? dx.immediate : opB;

	always_comb begin
		case (dx.ctrl.aluOp)
			cpuPkg::aluAdd:  aluResult = aluA + aluB;
			cpuPkg::aluSub:  aluResult = aluA - aluB;
			cpuPkg::aluXor:  aluResult = aluA ^ aluB;
			cpuPkg::aluLlb:  aluResult = {opA[15:8], dx.byteData};
			cpuPkg::aluLhb:  aluResult = {dx.byteData, opA[7:0]};
			cpuPkg::aluPass: aluResult = opA;
			default:         aluResult = opA;
		endcase
	end

	// z only moves for valid add/sub/xor/addi
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			zeroFlag <= 1'b0;
		else if (dx.valid && dx.ctrl.setsZero)
			zeroFlag <= (aluResult == '0);
	end

	// bz target: pc+2 plus the word offset
	assign branchOfs  = {{(`CPU_XLEN-9){dx.byteData[7]}}, dx.byteData, 1'b0};
	assign redirectPc = dx.pcPlus2 + branchOfs;
	assign redirect   = dx.valid && dx.ctrl.isBranch && zeroFlag; // flag from older ops

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			xm.valid <= 1'b0;
		else
			xm.valid <= dx.valid;
	end

	always_ff @(posedge clk) begin
		xm.ctrl      <= dx.ctrl;
		xm.aluResult <= aluResult;
		xm.storeData <= opA;                         // forwarded rd for sw
	end

endmodule

// ==== decodeStage.sv ====
`include "cpu_settings.svh"

module decodeStage (
	input  logic                 clk,
	input  logic                 arstN,
	input  logic [`CPU_XLEN-1:0] instr,
	input  logic [`CPU_XLEN-1:0] pcPlus2,
	input  logic                 fetchValid,
	input  logic                 redirect,
	output logic                 stall,
	wbIf.consumer                wb,
	decExIf.producer             dx
);

	cpuPkg::opcodeE           opcode;
	logic [`CPU_REG_BITS-1:0] rd;
	logic [`CPU_REG_BITS-1:0] rs;
	logic [`CPU_REG_BITS-1:0] rt;
	logic [`CPU_REG_BITS-1:0] src1;
	logic [`CPU_REG_BITS-1:0] src2;
	logic                     useSrc1;
	logic                     useSrc2;
	cpuPkg::ctrlT             ctrl;
	logic [`CPU_XLEN-1:0]     regs [`CPU_NREGS];
	logic [`CPU_XLEN-1:0]     rdata1;
	logic [`CPU_XLEN-1:0]     rdata2;
	logic [`CPU_XLEN-1:0]     immExt;
	logic                     srcHit;

	assign opcode = cpuPkg::opcodeE'(instr[15:12]);
	assign rd     = instr[11:8];
	assign rs     = instr[7:4];
	assign rt     = instr[3:0];
	assign immExt = {{(`CPU_XLEN-4){instr[3]}}, instr[3:0]};

	always_comb begin
		ctrl        = '0;
		ctrl.aluOp  = cpuPkg::aluPass;
		ctrl.dstReg = rd;
		src1        = rs;
		src2        = rt;
		useSrc1     = 1'b0;
		useSrc2     = 1'b0;
		case (opcode)
			cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opXor: begin
				ctrl.aluOp    = (opcode == cpuPkg::opAdd) ? cpuPkg::aluAdd :
					(opcode == cpuPkg::opSub) ? cpuPkg::aluSub : cpuPkg::aluXor;
				ctrl.regWrite = 1'b1;
				ctrl.setsZero = 1'b1;
				useSrc1       = 1'b1;
				useSrc2       = 1'b1;
			end
			cpuPkg::opAddi, cpuPkg::opLw: begin
				ctrl.aluOp    = cpuPkg::aluAdd;  // rs + imm
				ctrl.useImm   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.setsZero = (opcode == cpuPkg::opAddi);
				ctrl.memRead  = (opcode == cpuPkg::opLw);
				useSrc1       = 1'b1;
			end
			cpuPkg::opSw: begin
				ctrl.aluOp    = cpuPkg::aluAdd;
				ctrl.useImm   = 1'b1;
				ctrl.memWrite = 1'b1;
				src1          = rd;              // store data
				src2          = rs;              // address base
				useSrc1       = 1'b1;
				useSrc2       = 1'b1;
			end
			cpuPkg::opLlb, cpuPkg::opLhb: begin
				ctrl.aluOp    = (opcode == cpuPkg::opLlb) ? cpuPkg::aluLlb : cpuPkg::aluLhb;
				ctrl.regWrite = 1'b1;
				src1          = rd;              // old value keeps the other byte
				useSrc1       = 1'b1;
			end
			cpuPkg::opBz:  ctrl.isBranch = 1'b1;
			cpuPkg::opHlt: ctrl.isHalt   = 1'b1;
			default: ;                         // unused opcodes fall through as no-ops
		endcase
	end

	// register file, written from writeback
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (wb.wbEn) begin
			regs[wb.wbReg] <= wb.wbData;
		end
	end

	// r0 reads zero, same-cycle writeback passes straight through
	assign rdata1 = (src1 == '0) ? '0 :
		(wb.wbEn && wb.wbReg == src1) ? wb.wbData : regs[src1];
	assign rdata2 = (src2 == '0) ? '0 :
		(wb.wbEn && wb.wbReg == src2) ? wb.wbData : regs[src2];

	// lw in execute whose target is needed here, data not ready until writeback
	assign srcHit = (useSrc1 && src1 == dx.ctrl.dstReg) || (useSrc2 && src2 == dx.ctrl.dstReg);
	assign stall  = fetchValid && dx.valid && dx.ctrl.memRead &&
		dx.ctrl.dstReg != '0 && srcHit;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			dx.valid <= 1'b0;
		else
			dx.valid <= fetchValid && !stall && !redirect; // bubble on hold or flush
	end

	always_ff @(posedge clk) begin
		dx.ctrl      <= ctrl;
		dx.pcPlus2   <= pcPlus2;
		dx.operand1  <= rdata1;
		dx.operand2  <= rdata2;
		dx.src1      <= src1;
		dx.src2      <= src2;
		dx.immediate <= immExt;
		dx.byteData  <= instr[7:0];
	end

endmodule

// ==== fetchStage.sv ====
`include "cpu_settings.svh"

module fetchStage (
	input  logic                      clk,
	input  logic                      arstN,
	input  logic                      imemWe,      // program load port
	input  logic [`CPU_IMEM_BITS-1:0] imemAddr,
	input  logic [`CPU_XLEN-1:0]      imemData,
	input  logic                      stall,       // load-use hold from decode
	input  logic                      redirect,    // taken bz in execute
	input  logic [`CPU_XLEN-1:0]      redirectPc,
	output logic [`CPU_XLEN-1:0]      pc,
	output logic [`CPU_XLEN-1:0]      instr,       // fetch/decode register
	output logic [`CPU_XLEN-1:0]      pcPlus2,
	output logic                      fetchValid
);

	logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_WORDS];
	logic [`CPU_XLEN-1:0] fetchWord;
	logic [`CPU_XLEN-1:0] pcNext;
	logic                 fetchHalt;

	always_ff @(posedge clk) begin
		if (imemWe)
			imem[imemAddr] <= imemData; // synchronous load
	end

	assign fetchWord = imem[pc[`CPU_IMEM_BITS:1]]; // byte pc, word array
	assign pcNext    = pc + `CPU_XLEN'd2;
	// a halt at the pc keeps the pc parked on it
	assign fetchHalt = cpuPkg::opcodeE'(fetchWord[15:12]) == cpuPkg::opHlt;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pc <= '0;
		else if (redirect)
			pc <= redirectPc;           // branch beats stall and halt
		else if (!stall && !fetchHalt)
			pc <= pcNext;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			fetchValid <= 1'b0;
		else if (redirect)
			fetchValid <= 1'b0;         // squash wrong-path fetch
		else if (!stall)
			fetchValid <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			instr   <= fetchWord;
			pcPlus2 <= pcNext;          // bz target base
		end
	end

endmodule

// ==== cpuIf.sv ====
`include "cpu_settings.svh"

// decode/execute pipeline register contents
interface decExIf;
	logic                     valid;
	cpuPkg::ctrlT             ctrl;
	logic [`CPU_XLEN-1:0]     pcPlus2;
	logic [`CPU_XLEN-1:0]     operand1;  // rs, or rd for llb/lhb/sw
	logic [`CPU_XLEN-1:0]     operand2;  // rt, or rs for sw
	logic [`CPU_REG_BITS-1:0] src1;      // source numbers kept for forwarding
	logic [`CPU_REG_BITS-1:0] src2;
	logic [`CPU_XLEN-1:0]     immediate; // sign-extended bits 3..0
	logic [7:0]               byteData;  // raw bits 7..0, llb/lhb byte and bz offset

	modport producer(output valid, ctrl, pcPlus2, operand1, operand2, src1, src2,
		immediate, byteData);
	modport consumer(input valid, ctrl, pcPlus2, operand1, operand2, src1, src2,
		immediate, byteData);
endinterface

// execute/memory pipeline register contents
interface exMemIf;
	logic                 valid;
	cpuPkg::ctrlT         ctrl;
	logic [`CPU_XLEN-1:0] aluResult;  // also the data bus address
	logic [`CPU_XLEN-1:0] storeData;

	modport producer(output valid, ctrl, aluResult, storeData);
	modport consumer(input valid, ctrl, aluResult, storeData);
endinterface

// register write port plus the two forwarding sources
interface wbIf;
	logic                     wbEn;       // already excludes r0
	logic [`CPU_REG_BITS-1:0] wbReg;
	logic [`CPU_XLEN-1:0]     wbData;
	logic                     memFwdEn;   // alu result sitting in memory stage
	logic [`CPU_REG_BITS-1:0] memFwdReg;
	logic [`CPU_XLEN-1:0]     memFwdData;

	modport producer(output wbEn, wbReg, wbData, memFwdEn, memFwdReg, memFwdData);
	modport consumer(input wbEn, wbReg, wbData, memFwdEn, memFwdReg, memFwdData);
endinterface

// ==== cpuPkg.sv ====
`include "cpu_settings.svh"

package cpuPkg;

	// instruction opcodes in bits 15..12, gaps decode as no-ops
	typedef enum logic [3:0] {
		opAdd  = 4'd0,
		opSub  = 4'd1,
		opXor  = 4'd2,
		opAddi = 4'd3,
		opLw   = 4'd8,
		opSw   = 4'd9,
		opLlb  = 4'd10,
		opLhb  = 4'd11,
		opBz   = 4'd12,
		opHlt  = 4'd15
	} opcodeE;

	typedef enum logic [2:0] {
		aluAdd,  // add, also address calc for lw/sw
		aluSub,
		aluXor,
		aluLlb,  // low byte merge
		aluLhb,  // high byte merge
		aluPass  // no-ops, result unused
	} aluOpE;

	// control bundle that rides down the pipe with each instruction
	typedef struct packed {
		aluOpE                     aluOp;
		logic                      useImm;   // b operand is the sign-extended imm
		logic                      regWrite;
		logic                      memRead;
		logic                      memWrite;
		logic                      setsZero; // only arithmetic touches z
		logic                      isBranch;
		logic                      isHalt;
		logic [`CPU_REG_BITS-1:0]  dstReg;
	} ctrlT;

endpackage

// ==== cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath and instruction word width
`define CPU_XLEN 16

// architectural registers, r0 hardwired to zero
`define CPU_NREGS 16
`define CPU_REG_BITS $clog2(`CPU_NREGS)

// instruction memory, one word per entry, loaded through the write port
`define CPU_IMEM_WORDS 256
`define CPU_IMEM_BITS $clog2(`CPU_IMEM_WORDS)

`endif
